// ==== verilog/lc3b_types.sv ====
package lc3b_types;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

typedef logic [15:0] lc3b_word; // instruction, data or byte address.
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp; // n, z, p from msb down.
typedef logic [4:0] lc3b_imm5;
typedef logic [8:0] lc3b_offset9; // in words, scaled by 2.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcodes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

endpackage : lc3b_types

// ==== verilog/lc3b_pipe_types.sv ====
package lc3b_pipe_types;

// fetch sequencing.
typedef enum logic [1:0] {
	st_fetch,
	st_discard, // waiting out a reply from the squashed path.
	st_halt
} fetch_state;

// operation carried from decode into execute.
typedef enum logic [2:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass, // control flow, no register write.
	alu_none
} alu_op;

endpackage : lc3b_pipe_types

// ==== verilog/flow_control.sv ====
`timescale 1ns/1ps

module flow_control import lc3b_pipe_types::*;
(
	input logic clk,
	input logic reset,
	input logic resp_a,
	input logic redirect,
	input logic halt,
	output logic mem_read1,
	output logic fetch_valid,
	output logic pc_step,
	output logic halted
);

fetch_state state, state_next;
logic busy; // request still open from an earlier cycle.
logic gap; // idle cycle after each response.

// a new request never starts in a redirect or halt cycle.
assign mem_read1 = !reset && !gap && (busy || (state == st_fetch && !redirect && !halt));
assign fetch_valid = resp_a && state == st_fetch;
assign pc_step = fetch_valid;
assign halted = state == st_halt;

always_comb begin
	state_next = state;
	case (state)
		st_fetch: begin
			if (halt)
				state_next = st_halt;
			else if (redirect && mem_read1 && !resp_a)
				state_next = st_discard; // reply in flight belongs to old path.
		end
		st_discard: begin
			if (halt)
				state_next = st_halt;
			else if (resp_a)
				state_next = st_fetch;
		end
		default: state_next = st_halt; // parked until reset.
	endcase
end

always_ff @(posedge clk) begin
	if (reset) begin
		state <= st_fetch;
		busy <= 1'b0;
		gap <= 1'b0;
	end else begin
		state <= state_next;
		busy <= mem_read1 && !resp_a;
		gap <= resp_a;
	end
end

assert property (@(posedge clk) disable iff (reset) resp_a |-> mem_read1)
	else $error("resp_a without an open request");

assert property (@(posedge clk) disable iff (reset) fetch_valid |-> !$past(redirect))
	else $error("fetch delivered right after a redirect");

endmodule : flow_control

// ==== verilog/program_counter.sv ====
`timescale 1ns/1ps

module program_counter import lc3b_types::*;
#(
	parameter lc3b_word RESET_PC = 16'h0000
)
(
	input logic clk,
	input logic reset,
	input logic pc_step,
	input logic redirect,
	input lc3b_word target,
	input logic mem_read1,
	output lc3b_word pc
);

logic pend; // target waiting for the open request to finish.
lc3b_word pend_target;

always_ff @(posedge clk) begin
	if (reset) begin
		pc <= RESET_PC;
		pend <= 1'b0;
	end else if (redirect) begin
		if (mem_read1) begin
			pend <= 1'b1;
		end else begin
			pc <= target;
			pend <= 1'b0;
		end
	end else if (pend && !mem_read1) begin
		pc <= pend_target;
		pend <= 1'b0;
	end else if (pc_step) begin
		pc <= pc + 16'd2;
	end
end

always_ff @(posedge clk) begin
	if (redirect && mem_read1)
		pend_target <= target;
end

// address must hold for the whole request.
assert property (@(posedge clk) disable iff (reset)
	mem_read1 && $past(mem_read1) && !$past(reset) |-> $stable(pc))
	else $error("fetch address moved during a request");

endmodule : program_counter

// ==== verilog/instruction_decode.sv ====
`timescale 1ns/1ps

module instruction_decode import lc3b_types::*, lc3b_pipe_types::*;
(
	input logic clk,
	input logic reset,
	input logic fetch_valid,
	input lc3b_word instr,
	input lc3b_word pc,
	input logic squash,
	input logic reg_write,
	input lc3b_reg reg_dest,
	input lc3b_word reg_data,
	output logic ex_valid,
	output alu_op ex_op,
	output lc3b_opcode ex_opcode,
	output lc3b_reg ex_dest,
	output lc3b_word ex_a,
	output lc3b_word ex_b,
	output lc3b_word ex_pc,
	output lc3b_nzp ex_nzp,
	output lc3b_offset9 ex_offset
);

logic if_valid;
lc3b_word if_ir, if_pc;
lc3b_opcode opcode;
lc3b_reg sr1, sr2;
lc3b_imm5 imm5;
lc3b_word imm_sext, rd_a, rd_b;
lc3b_word regs [8];
alu_op op;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IF/ID register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk) begin
	if (reset || squash)
		if_valid <= 1'b0;
	else
		if_valid <= fetch_valid; // empty unless fetch delivered.
end

always_ff @(posedge clk) begin
	if (fetch_valid) begin
		if_ir <= instr;
		if_pc <= pc + 16'd2;
	end
end

assign opcode = lc3b_opcode'(if_ir[15:12]);
assign sr1 = if_ir[8:6];
assign sr2 = if_ir[2:0];
assign imm5 = if_ir[4:0];
assign imm_sext = {{11{imm5[4]}}, imm5};

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < 8; i++)
			regs[i] <= '0;
	end else if (reg_write) begin
		regs[reg_dest] <= reg_data;
	end
end

// write-through, so a same-cycle write is seen.
assign rd_a = (reg_write && reg_dest == sr1) ? reg_data : regs[sr1];
assign rd_b = (reg_write && reg_dest == sr2) ? reg_data : regs[sr2];

always_comb begin
	case (opcode)
		op_add: op = alu_add;
		op_and: op = alu_and;
		op_not: op = alu_not;
		op_br, op_trap: op = alu_pass;
		default: op = alu_none; // retires as nop.
	endcase
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk) begin
	if (reset || squash)
		ex_valid <= 1'b0;
	else
		ex_valid <= if_valid;
end

always_ff @(posedge clk) begin
	ex_op <= op;
	ex_opcode <= opcode;
	ex_dest <= if_ir[11:9];
	ex_a <= rd_a;
	ex_b <= if_ir[5] ? imm_sext : rd_b; // imm5 form.
	ex_pc <= if_pc;
	ex_nzp <= if_ir[11:9]; // same field as dest, br reads it as nzp.
	ex_offset <= if_ir[8:0];
end

endmodule : instruction_decode

// ==== verilog/execution_module.sv ====
`timescale 1ns/1ps

module execution_module import lc3b_types::*, lc3b_pipe_types::*;
(
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input alu_op ex_op,
	input lc3b_opcode ex_opcode,
	input lc3b_reg ex_dest,
	input lc3b_word ex_a,
	input lc3b_word ex_b,
	input lc3b_word ex_pc,
	input lc3b_nzp ex_nzp,
	input lc3b_offset9 ex_offset,
	output logic reg_write,
	output lc3b_reg reg_dest,
	output lc3b_word reg_data,
	output logic redirect,
	output lc3b_word target,
	output logic halt,
	output logic squash
);

lc3b_word result, br_target;
lc3b_nzp cc, cc_next;
logic stopped; // set once trap retires.
logic live, write_en, taken, trap;

assign live = ex_valid && !stopped;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu and condition codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
	case (ex_op)
		alu_add: result = ex_a + ex_b;
		alu_and: result = ex_a & ex_b;
		alu_not: result = ~ex_a;
		alu_pass: result = ex_b;
		default: result = '0;
	endcase
end

assign write_en = live && (ex_op == alu_add || ex_op == alu_and || ex_op == alu_not);
assign cc_next = result[15] ? 3'b100 : (result == '0) ? 3'b010 : 3'b001;

// branch resolution.
assign br_target = ex_pc + {{6{ex_offset[8]}}, ex_offset, 1'b0};
assign taken = live && ex_op == alu_pass && ex_opcode == op_br && |(ex_nzp & cc);
assign trap = live && ex_opcode == op_trap;

assign squash = redirect;

always_ff @(posedge clk) begin
	if (reset) begin
		reg_write <= 1'b0;
		redirect <= 1'b0;
		halt <= 1'b0;
		stopped <= 1'b0;
		cc <= 3'b010; // z after reset.
	end else begin
		reg_write <= write_en;
		redirect <= taken;
		halt <= trap;
		if (trap)
			stopped <= 1'b1;
		if (write_en)
			cc <= cc_next; // lands with the register write.
	end
end

always_ff @(posedge clk) begin
	reg_dest <= ex_dest;
	reg_data <= result;
	target <= br_target;
end

endmodule : execution_module

// ==== verilog/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath import lc3b_types::*, lc3b_pipe_types::*;
#(
	parameter lc3b_word RESET_PC = 16'h0000
)
(
	input logic clk,
	input logic reset,
	input logic resp_a,
	input lc3b_word mem_rdata1,
	output lc3b_word mem_addr1,
	output logic mem_read1,
	output logic reg_write,
	output lc3b_reg reg_dest,
	output lc3b_word reg_data,
	output logic halted
);

// fetch control.
logic fetch_valid, pc_step, redirect, halt, squash;
lc3b_word target;

// ID/EX fields.
logic ex_valid;
alu_op ex_op;
lc3b_opcode ex_opcode;
lc3b_reg ex_dest;
lc3b_word ex_a, ex_b, ex_pc;
lc3b_nzp ex_nzp;
lc3b_offset9 ex_offset;

flow_control fetch_fsm
(
	.clk(clk),
	.reset(reset),
	.resp_a(resp_a),
	.redirect(redirect),
	.halt(halt),
	.mem_read1(mem_read1),
	.fetch_valid(fetch_valid),
	.pc_step(pc_step),
	.halted(halted)
);

program_counter #(.RESET_PC(RESET_PC)) pc_reg
(
	.clk(clk),
	.reset(reset),
	.pc_step(pc_step),
	.redirect(redirect),
	.target(target),
	.mem_read1(mem_read1),
	.pc(mem_addr1)
);

instruction_decode id_stage
(
	.clk(clk),
	.reset(reset),
	.fetch_valid(fetch_valid),
	.instr(mem_rdata1),
	.pc(mem_addr1),
	.squash(squash),
	.reg_write(reg_write),
	.reg_dest(reg_dest),
	.reg_data(reg_data),
	.ex_valid(ex_valid),
	.ex_op(ex_op),
	.ex_opcode(ex_opcode),
	.ex_dest(ex_dest),
	.ex_a(ex_a),
	.ex_b(ex_b),
	.ex_pc(ex_pc),
	.ex_nzp(ex_nzp),
	.ex_offset(ex_offset)
);

execution_module ex_stage
(
	.clk(clk),
	.reset(reset),
	.ex_valid(ex_valid),
	.ex_op(ex_op),
	.ex_opcode(ex_opcode),
	.ex_dest(ex_dest),
	.ex_a(ex_a),
	.ex_b(ex_b),
	.ex_pc(ex_pc),
	.ex_nzp(ex_nzp),
	.ex_offset(ex_offset),
	.reg_write(reg_write),
	.reg_dest(reg_dest),
	.reg_data(reg_data),
	.redirect(redirect),
	.target(target),
	.halt(halt),
	.squash(squash)
);

endmodule : cpu_datapath

// ==== test/lc3b_model.svh ====
`ifndef LC3B_MODEL_SVH
`define LC3B_MODEL_SVH

// runs the loaded program one instruction at a time.
// fills exp_dest and exp_data in order and returns the write count.
// fetches counts every fetch, plus two per taken branch for the wrong path.
function automatic int run_model(output int fetches);
	lc3b_word r [8];
	lc3b_word pc, ir, b, res;
	lc3b_nzp cc;
	for (int i = 0; i < 8; i++)
		r[i] = '0;
	cc = 3'b010;
	pc = RESET_PC;
	fetches = 0;
	exp_dest.delete();
	exp_data.delete();
	for (int step = 0; step < 500; step++) begin
		ir = word_at(pc);
		pc = pc + 16'd2;
		fetches++;
		if (ir[15:12] == 4'hF)
			break; // trap halts.
		b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
		case (ir[15:12])
			4'h1, 4'h5, 4'h9: begin
				if (ir[15:12] == 4'h1)
					res = r[ir[8:6]] + b;
				else if (ir[15:12] == 4'h5)
					res = r[ir[8:6]] & b;
				else
					res = ~r[ir[8:6]];
				r[ir[11:9]] = res;
				exp_dest.push_back(ir[11:9]);
				exp_data.push_back(res);
				cc = res[15] ? 3'b100 : (res == 16'h0000) ? 3'b010 : 3'b001;
			end
			4'h0: begin
				if (|(ir[11:9] & cc)) begin
					pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
					fetches += 2;
				end
			end
			default: ; // nop.
		endcase
	end
	return exp_dest.size();
endfunction

`endif

// ==== test/cpu_datapath_tb.sv ====
`timescale 1ns/1ps

module cpu_datapath_tb import lc3b_types::*;
();

localparam lc3b_word RESET_PC = 16'h0100;

logic clk, reset, resp_a, mem_read1, reg_write, halted;
lc3b_word mem_rdata1, mem_addr1, reg_data;
lc3b_reg reg_dest;

lc3b_word prog [64];
int prog_len;
lc3b_reg exp_dest [$];
lc3b_word exp_data [$];
lc3b_word fetch_log [$];
integer seed = 32'h4ba852db;
int errors, writes, tests, passed, failed, cycles, limit;
string test_name;

cpu_datapath #(.RESET_PC(RESET_PC)) DUT
(
	.clk(clk),
	.reset(reset),
	.resp_a(resp_a),
	.mem_rdata1(mem_rdata1),
	.mem_addr1(mem_addr1),
	.mem_read1(mem_read1),
	.reg_write(reg_write),
	.reg_dest(reg_dest),
	.reg_data(reg_data),
	.halted(halted)
);

// outside the program, a nop that carries the address.
function automatic lc3b_word word_at(lc3b_word addr);
	lc3b_word idx;
	idx = (addr - RESET_PC) >> 1;
	if (idx < prog_len)
		return prog[idx];
	return {4'hD, addr[11:0] ^ {8'h00, addr[15:12]}};
endfunction

`include "lc3b_model.svh"

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic emit(lc3b_word w);
	prog[prog_len] = w;
	prog_len++;
endtask

function automatic lc3b_word alu_reg(logic [3:0] op, lc3b_reg dr, lc3b_reg sa, lc3b_reg sb);
	return {op, dr, sa, 3'b000, sb};
endfunction

function automatic lc3b_word alu_imm(logic [3:0] op, lc3b_reg dr, lc3b_reg sa, lc3b_imm5 imm);
	return {op, dr, sa, 1'b1, imm};
endfunction

function automatic lc3b_word br(lc3b_nzp nzp, lc3b_offset9 off);
	return {4'h0, nzp, off};
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock, memory, monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

initial begin
	logic req, rst, pending;
	lc3b_word addr;
	int lat;
	resp_a = 1'b0;
	mem_rdata1 = '0;
	pending = 1'b0;
	lat = 0;
	forever begin
		@(negedge clk);
		req = mem_read1;
		rst = reset;
		addr = mem_addr1;
		if (!rst && req && !pending && !resp_a) begin
			pending = 1'b1;
			lat = 1 + ($unsigned($random(seed)) % 4);
			fetch_log.push_back(addr);
		end
		@(posedge clk);
		#1;
		resp_a = 1'b0;
		if (rst) begin
			pending = 1'b0;
		end else if (pending) begin
			lat--;
			if (lat == 0) begin
				resp_a = 1'b1;
				mem_rdata1 = word_at(addr);
				pending = 1'b0;
			end
		end
	end
end

task automatic check_reg(string what, lc3b_reg expected, lc3b_reg actual);
	if (expected !== actual) begin
		$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		errors++;
	end
endtask

task automatic check_word(string what, lc3b_word expected, lc3b_word actual);
	if (expected !== actual) begin
		$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
		errors++;
	end
endtask

// compares every write with the next model entry.
initial begin
	forever begin
		@(negedge clk);
		if (!reset && reg_write === 1'b1) begin
			writes++;
			if (exp_dest.size() == 0) begin
				$display("%s: register write after the last expected one", test_name);
				errors++;
			end else begin
				check_reg("dest", exp_dest.pop_front(), reg_dest);
				check_word("data", exp_data.pop_front(), reg_data);
			end
		end
	end
end

initial begin
	while (cycles <= limit) begin
		@(posedge clk);
		cycles++;
	end
	$display("%s: timed out after %0d cycles", test_name, cycles);
	$display("TESTS FAILED");
	$finish;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test runner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic run_program(string name, logic check_addr, logic check_idle);
	int fetches, n_exp, start_err, start_wr;
	test_name = name;
	n_exp = run_model(fetches);
	start_err = errors;
	start_wr = writes;
	cycles = 0;
	limit = fetches * 6 + 50;
	fetch_log.delete();
	@(posedge clk);
	#1 reset = 1'b1;
	repeat (2) begin
		@(negedge clk);
		if (mem_read1 !== 1'b0) begin
			$display("%s: fetch request during reset", name);
			errors++;
		end
	end
	@(posedge clk);
	#1 reset = 1'b0;
	while (halted !== 1'b1)
		@(negedge clk);
	repeat (3) @(negedge clk);
	if (writes - start_wr != n_exp) begin
		$display("FAILED %s write count: expected %0d, actual %0d", name, n_exp,
			writes - start_wr);
		errors++;
	end
	if (check_addr) begin
		check_word("first fetch", RESET_PC, fetch_log[0]);
		for (int i = 1; i < fetch_log.size(); i++)
			check_word("fetch step", fetch_log[i-1] + 16'd2, fetch_log[i]);
	end
	if (check_idle) begin
		while (mem_read1 !== 1'b0)
			@(negedge clk); // last open request drains.
		repeat (20) begin
			@(negedge clk);
			if (mem_read1 !== 1'b0 || halted !== 1'b1) begin
				$display("%s: fetch restarted after halt", name);
				errors++;
			end
		end
	end
	tests++;
	if (errors == start_err) begin
		passed++;
		$display("pass %s, %0d writes", name, n_exp);
	end else begin
		failed++;
		$display("fail %s", name);
	end
endtask

initial begin
	reset = 1'b1;
	errors = 0;
	writes = 0;
	tests = 0;
	passed = 0;
	failed = 0;
	cycles = 0;
	limit = 100;

	prog_len = 0; // straight line.
	emit(alu_imm(4'h1, 1, 0, 5));
	emit(alu_imm(4'h1, 2, 1, -3));
	emit(alu_imm(4'h5, 3, 2, 7));
	emit(alu_reg(4'h9, 4, 3, 0) | 16'h003F);
	emit(alu_reg(4'h1, 5, 4, 1));
	emit(alu_reg(4'h5, 6, 5, 4));
	emit(16'hF025);
	run_program("straight", 1'b1, 1'b0);

	prog_len = 0; // dependent alu chain.
	emit(alu_imm(4'h1, 1, 1, -16));
	emit(alu_reg(4'h1, 1, 1, 1));
	emit(alu_imm(4'h5, 2, 1, 15));
	emit(alu_reg(4'h9, 2, 2, 0) | 16'h003F);
	emit(alu_reg(4'h5, 3, 2, 1));
	emit(alu_imm(4'h1, 3, 3, 15));
	emit(alu_reg(4'h1, 7, 3, 2));
	emit(alu_imm(4'h5, 7, 7, 0));
	emit(16'hF025);
	run_program("alu chain", 1'b0, 1'b0);

	prog_len = 0; // every nzp against z, p and n codes.
	emit(alu_imm(4'h5, 1, 1, 0));
	emit(br(3'b100, 1));
	emit(br(3'b010, 1));
	emit(alu_imm(4'h1, 2, 2, 1));
	emit(alu_imm(4'h1, 3, 3, 4));
	emit(br(3'b101, 1));
	emit(alu_imm(4'h1, 4, 4, 1));
	emit(alu_imm(4'h1, 5, 5, -2));
	emit(br(3'b011, 1));
	emit(br(3'b000, 1));
	emit(alu_imm(4'h1, 6, 6, 1));
	emit(br(3'b111, 1));
	emit(alu_imm(4'h1, 6, 6, 2));
	emit(alu_imm(4'h1, 3, 0, 4));
	emit(alu_imm(4'h1, 4, 4, 3));
	emit(alu_imm(4'h1, 3, 3, -1));
	emit(br(3'b001, -3));
	emit(16'hF025);
	run_program("branches", 1'b0, 1'b0);

	prog_len = 0; // long loop, many redirects under random latency.
	emit(alu_imm(4'h1, 1, 0, 10));
	emit(alu_reg(4'h1, 2, 2, 1));
	emit(br(3'b111, 1));
	emit(alu_imm(4'h1, 7, 7, 1));
	emit(alu_imm(4'h1, 1, 1, -1));
	emit(br(3'b110, 1));
	emit(br(3'b111, -6));
	emit(alu_reg(4'h9, 3, 2, 0) | 16'h003F);
	emit(16'hF025);
	run_program("random latency loop", 1'b0, 1'b0);

	prog_len = 0; // nothing after the trap may write.
	emit(alu_imm(4'h1, 1, 0, 9));
	emit(16'hF025);
	emit(alu_imm(4'h1, 2, 0, 1));
	emit(alu_imm(4'h1, 3, 0, 2));
	run_program("trap halt", 1'b0, 1'b1);

	$display("writes %0d, tests %0d, passed %0d, failed %0d", writes, tests, passed, failed);
	if (failed == 0 && errors == 0) begin
		$display("TESTS PASSED");
	end else begin
		$display("TESTS FAILED");
	end
	$finish;
end

endmodule : cpu_datapath_tb

// ==== list.f ====
+incdir+test
verilog/lc3b_types.sv
verilog/lc3b_pipe_types.sv
verilog/flow_control.sv
verilog/program_counter.sv
verilog/instruction_decode.sv
verilog/execution_module.sv
verilog/cpu_datapath.sv
test/cpu_datapath_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = cpu_datapath_tb
FILELIST = list.f

SOURCES = $(shell grep -v '^+' $(FILELIST)) test/lc3b_model.svh
BIN = obj_dir/V$(TOP)
LOG = sim.log

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TESTS FAILED" $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
